/* dv/tb_vx_mem_tile.sv */
module tb_vx_mem_tile;

    localparam int          PERIOD  = 40;
    localparam int          NUM     = 21;
    localparam logic [31:0] IO_ADDR = 32'hFFFF_FF00;

    typedef enum logic [2:0] {
        OP_IREAD,
        OP_DREAD,
        OP_DWRITE,
        OP_IO,
        OP_SNOOP,
        OP_BOTH
    } op_t;

    // For OP_BOTH the data column holds the load address
    typedef struct packed {
        op_t         op;
        logic [31:0] addr;
        logic [31:0] data;
        logic [1:0]  rd_inc;
    } entry_t;

    entry_t tests [NUM] = '{
        '{OP_IREAD,  32'h0000_0100, 32'h0000_0000, 2'd1},
        '{OP_IREAD,  32'h0000_0104, 32'h0000_0000, 2'd0},
        '{OP_IREAD,  32'h0000_010C, 32'h0000_0000, 2'd0},
        '{OP_DWRITE, 32'h0000_0200, 32'h1111_0000, 2'd1},
        '{OP_DREAD,  32'h0000_0200, 32'h0000_0000, 2'd0},
        '{OP_DWRITE, 32'h0000_0208, 32'h2222_0000, 2'd0},
        '{OP_IO,     IO_ADDR,       32'h3333_0000, 2'd0},
        '{OP_DREAD,  32'h0000_0204, 32'h0000_0000, 2'd0},
        '{OP_SNOOP,  32'h0000_0400, 32'h0000_0000, 2'd0},
        '{OP_DREAD,  32'h0000_020C, 32'h0000_0000, 2'd0},
        '{OP_SNOOP,  32'h0000_0210, 32'h0000_0000, 2'd0},
        '{OP_DREAD,  32'h0000_0208, 32'h0000_0000, 2'd1},
        '{OP_BOTH,   32'h0000_0300, 32'h0000_0340, 2'd2},
        '{OP_DWRITE, 32'h0000_0310, 32'h4444_0000, 2'd1},
        '{OP_DWRITE, 32'h0000_0314, 32'h5555_0000, 2'd0},
        '{OP_IREAD,  32'h0000_0310, 32'h0000_0000, 2'd1},
        '{OP_IREAD,  32'h0000_0314, 32'h0000_0000, 2'd0},
        '{OP_SNOOP,  32'h0000_0318, 32'h0000_0000, 2'd0},
        '{OP_IREAD,  32'h0000_031C, 32'h0000_0000, 2'd1},
        '{OP_DREAD,  32'h0000_0300, 32'h0000_0000, 2'd1},
        '{OP_IREAD,  32'h0000_0104, 32'h0000_0000, 2'd1}
    };

    logic                  clk;
    logic                  reset;
    logic                  i_req_valid;
    logic                  i_req_ready;
    logic                  i_rsp_valid;
    logic                  d_req_valid;
    logic                  d_req_ready;
    logic                  d_rsp_valid;
    logic                  io_valid;
    logic                  llc_snp_req_valid;
    logic [31:0]           llc_snp_req_addr;
    logic [31:0]           io_data;
    vx_mem_pkg::core_req_t i_req;
    vx_mem_pkg::core_req_t d_req;
    vx_mem_pkg::core_rsp_t i_rsp;
    vx_mem_pkg::core_rsp_t d_rsp;
    logic                  dram_req_valid;
    logic                  dram_req_ready;
    logic                  dram_rsp_valid;
    logic                  dram_rsp_ready;
    vx_mem_pkg::dram_req_t dram_req;
    vx_mem_pkg::dram_rsp_t dram_rsp;
    logic [2:0]            lat;
    int                    read_count;
    int                    write_count;

    logic [31:0]           lfsr_q;
    logic [31:0]           shadow [logic [31:0]];
    int                    errors;
    int                    failed_tests;
    int                    cur_test;
    int                    i_got;
    int                    d_got;
    int                    io_got;
    logic [31:0]           i_data;
    logic [31:0]           d_data;
    logic [31:0]           io_val;
    logic                  i_ack;
    logic                  d_ack;

    vx_mem_tile #(
        .IO_BUS_ADDR (IO_ADDR),
        .ILINE_WORDS (4),
        .DLINE_WORDS (8)
    ) dut_i (
        .clk               (clk),
        .reset             (reset),
        .i_req_valid       (i_req_valid),
        .i_req             (i_req),
        .i_req_ready       (i_req_ready),
        .i_rsp_valid       (i_rsp_valid),
        .i_rsp             (i_rsp),
        .d_req_valid       (d_req_valid),
        .d_req             (d_req),
        .d_req_ready       (d_req_ready),
        .d_rsp_valid       (d_rsp_valid),
        .d_rsp             (d_rsp),
        .io_valid          (io_valid),
        .io_data           (io_data),
        .llc_snp_req_valid (llc_snp_req_valid),
        .llc_snp_req_addr  (llc_snp_req_addr),
        .dram_req_valid    (dram_req_valid),
        .dram_req          (dram_req),
        .dram_req_ready    (dram_req_ready),
        .dram_rsp_valid    (dram_rsp_valid),
        .dram_rsp          (dram_rsp),
        .dram_rsp_ready    (dram_rsp_ready)
    );

    vx_dram_model dram_i (
        .clk         (clk),
        .reset       (reset),
        .lat         (lat),
        .req_valid   (dram_req_valid),
        .req         (dram_req),
        .req_ready   (dram_req_ready),
        .rsp_valid   (dram_rsp_valid),
        .rsp         (dram_rsp),
        .rsp_ready   (dram_rsp_ready),
        .read_count  (read_count),
        .write_count (write_count)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
            r      = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // Expected memory word from the shadow or the power-up pattern
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        if (shadow.exists(a >> 2)) begin
            return shadow[a >> 2];
        end
        return (a >> 2) ^ 32'hA5A5_0000;
    endfunction

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %0t test %0d %s: got %h, expected %h",
                     $time, cur_test, what, got, exp);
        end
    endtask

    task automatic sample_outputs();
        if (i_rsp_valid) begin
            i_got++;
            i_data = i_rsp.data;
            i_ack  = i_rsp.write_ack;
        end
        if (d_rsp_valid) begin
            d_got++;
            d_data = d_rsp.data;
            d_ack  = d_rsp.write_ack;
        end
        if (io_valid) begin
            io_got++;
            io_val = io_data;
        end
    endtask

    task automatic access(input bit use_i, input bit use_d, input logic [31:0] ia,
                          input vx_mem_pkg::core_req_t dq, input int d_rsps);
        bit i_pend;
        bit d_pend;
        bit i_take;
        bit d_take;
        i_pend = use_i;
        d_pend = use_d;
        @(posedge clk);
        i_req_valid <= use_i;
        i_req       <= '{write: 1'b0, addr: ia, data: 32'h0};
        d_req_valid <= use_d;
        d_req       <= dq;
        while (i_pend || d_pend || (i_got < int'(use_i)) || (d_got < d_rsps)) begin
            @(negedge clk);
            i_take = i_pend && i_req_ready;
            d_take = d_pend && d_req_ready;
            sample_outputs();
            @(posedge clk);
            lat <= 3'd1 + 3'(rand_bits(3) % 6);
            if (i_take) begin
                i_req_valid <= 1'b0;
                i_pend = 1'b0;
            end
            if (d_take) begin
                d_req_valid <= 1'b0;
                d_pend = 1'b0;
            end
        end
        // Extra cycles so stray pulses land in the counts
        repeat (3) begin
            @(negedge clk);
            sample_outputs();
        end
    endtask

    task automatic snoop(input logic [31:0] a);
        @(posedge clk);
        llc_snp_req_valid <= 1'b1;
        llc_snp_req_addr  <= a;
        @(posedge clk);
        llc_snp_req_valid <= 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
    endtask

    task automatic run_test(input int idx, input entry_t e);
        int                    rd0;
        int                    wr0;
        int                    err0;
        op_t                   op;
        logic [31:0]           wd;
        vx_mem_pkg::core_req_t dq;
        op       = e.op;
        cur_test = idx;
        wd       = e.data ^ rand_bits(32);
        dq.write = (op == OP_DWRITE) || (op == OP_IO);
        dq.addr  = (op == OP_BOTH) ? e.data : e.addr;
        dq.data  = wd;
        i_got    = 0;
        d_got    = 0;
        io_got   = 0;
        @(negedge clk);
        rd0  = read_count;
        wr0  = write_count;
        err0 = errors;
        case (op)
            OP_IREAD:            access(1'b1, 1'b0, e.addr, dq, 0);
            OP_DREAD, OP_DWRITE: access(1'b0, 1'b1, 32'h0, dq, 1);
            OP_IO:               access(1'b0, 1'b1, 32'h0, dq, 0);
            OP_BOTH:             access(1'b1, 1'b1, e.addr, dq, 1);
            default:             snoop(e.addr);
        endcase
        check_eq(read_count - rd0, 32'(e.rd_inc), "DRAM reads");
        check_eq(write_count - wr0, (op == OP_DWRITE) ? 1 : 0, "DRAM writes");
        check_eq(io_got, (op == OP_IO) ? 1 : 0, "io_valid pulses");
        check_eq(i_got, (op == OP_IREAD || op == OP_BOTH) ? 1 : 0, "fetch responses");
        check_eq(d_got, (op == OP_DREAD || op == OP_DWRITE || op == OP_BOTH) ? 1 : 0,
                 "data responses");
        case (op)
            OP_IREAD: begin
                check_eq(i_data, mem_word(e.addr), "fetch data");
                check_eq(32'(i_ack), 32'd0, "fetch write_ack");
            end
            OP_DREAD: begin
                check_eq(d_data, mem_word(e.addr), "load data");
                check_eq(32'(d_ack), 32'd0, "load write_ack");
            end
            OP_DWRITE: begin
                check_eq(32'(d_ack), 32'd1, "write_ack");
                check_eq(dram_i.mem[e.addr[11:2]], wd, "DRAM backing word");
                shadow[e.addr >> 2] = wd;
            end
            OP_IO: check_eq(io_val, wd, "io_data");
            OP_BOTH: begin
                check_eq(i_data, mem_word(e.addr), "fetch data");
                check_eq(d_data, mem_word(e.data), "load data");
                check_eq(32'(i_ack), 32'd0, "fetch write_ack");
                check_eq(32'(d_ack), 32'd0, "load write_ack");
            end
            default: begin
            end
        endcase
        if (errors != err0) begin
            failed_tests++;
        end
        $display("test %0d %s addr %h: %s", idx, op.name(), e.addr,
                 (errors == err0) ? "ok" : "FAILED");
    endtask

    initial begin
        lfsr_q            = 32'h2736_a8e5;
        errors            = 0;
        failed_tests      = 0;
        cur_test          = -1;
        reset             = 1'b1;
        lat               = 3'd1;
        i_req_valid       = 1'b0;
        i_req             = '0;
        d_req_valid       = 1'b0;
        d_req             = '0;
        llc_snp_req_valid = 1'b0;
        llc_snp_req_addr  = '0;
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_eq(32'({i_req_ready, d_req_ready, i_rsp_valid, d_rsp_valid,
                      dram_req_valid, io_valid}), 32'h30, "idle after reset");
        for (int t = 0; t < NUM; t++) begin
            run_test(t, tests[t]);
        end
        $display("Tests run: %0d, tests failed: %0d, checks failed: %0d",
                 NUM, failed_tests, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // Watchdog allows 40 cycles per table entry
    initial begin
        #(NUM * 40 * PERIOD);
        $display("Timed out after %0d cycles, the DUT stopped responding", NUM * 40);
        $display("Finished with errors");
        $finish;
    end

endmodule

/* dv/vx_dram_model.sv */
module vx_dram_model (
    input  logic                  clk,
    input  logic                  reset,

    // Read latency for the next accepted read, 1 to 6
    input  logic [2:0]            lat,

    input  logic                  req_valid,
    input  vx_mem_pkg::dram_req_t req,
    output logic                  req_ready,
    output logic                  rsp_valid,
    output vx_mem_pkg::dram_rsp_t rsp,
    input  logic                  rsp_ready,

    output int                    read_count,
    output int                    write_count
);

    logic [31:0] mem [0:1023];
    logic        pend_q;
    logic [2:0]  cnt_q;
    logic [9:0]  base;

    assign base      = req.addr[11:2];
    assign req_ready = 1'b1;
    assign rsp_valid = pend_q && (cnt_q == 3'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            pend_q      <= 1'b0;
            cnt_q       <= 3'd0;
            read_count  <= 0;
            write_count <= 0;
            // Power-up contents follow the word address
            for (int i = 0; i < 1024; i++) begin
                mem[i] <= 32'(i) ^ 32'hA5A5_0000;
            end
        end else begin
            if (rsp_valid && rsp_ready) begin
                pend_q <= 1'b0;
            end else if (pend_q && (cnt_q != 3'd0)) begin
                cnt_q <= cnt_q - 3'd1;
            end
            if (req_valid && req_ready && req.read) begin
                pend_q     <= 1'b1;
                cnt_q      <= lat - 3'd1;
                read_count <= read_count + 1;
                rsp.addr   <= req.addr;
                // Line is captured at acceptance
                for (int w = 0; w < vx_mem_pkg::DLINE_WORDS; w++) begin
                    rsp.data[w] <= mem[base + 10'(w)];
                end
            end
            if (req_valid && req_ready && req.write) begin
                write_count <= write_count + 1;
                for (int w = 0; w < vx_mem_pkg::DLINE_WORDS; w++) begin
                    mem[base + 10'(w)] <= req.data[w];
                end
            end
        end
    end

endmodule

/* rtl/vx_dram_arbiter.sv */
module vx_dram_arbiter (
    input  logic                  clk,
    input  logic                  reset,

    // Instruction side, reads only
    input  logic                  i_req_valid,
    input  logic [31:0]           i_req_addr,
    output logic                  i_req_ready,
    output logic                  i_rsp_valid,
    output vx_mem_pkg::iline_t    i_rsp_line,

    // Data side, reads and writes
    input  logic                  d_req_valid,
    input  vx_mem_pkg::dram_req_t d_req,
    output logic                  d_req_ready,
    output logic                  d_rsp_valid,
    output vx_mem_pkg::dline_t    d_rsp_line,

    // Shared DRAM channel
    output logic                  dram_req_valid,
    output vx_mem_pkg::dram_req_t dram_req,
    input  logic                  dram_req_ready,
    input  logic                  dram_rsp_valid,
    input  vx_mem_pkg::dram_rsp_t dram_rsp,
    output logic                  dram_rsp_ready
);

    logic                  rd_busy_q;
    logic                  rd_owner_d_q;
    logic                  prio_d_q;

    logic                  i_elig;
    logic                  d_elig;
    logic                  grant_i;
    logic                  grant_d;
    logic                  fire;
    vx_mem_pkg::dram_req_t i_wide;

    // Only one read may be in flight, writes can pass it
    assign i_elig = i_req_valid && !rd_busy_q;
    assign d_elig = d_req_valid && (!d_req.read || !rd_busy_q);

    // Round robin, the side that just won drops to low priority
    assign grant_i = i_elig && (!d_elig || !prio_d_q);
    assign grant_d = d_elig && !grant_i;

    assign i_wide = '{read: 1'b1, write: 1'b0, addr: i_req_addr, data: '0};

    assign dram_req_valid = grant_i || grant_d;
    assign dram_req       = grant_i ? i_wide : d_req;
    assign fire           = dram_req_valid && dram_req_ready;

    assign i_req_ready = grant_i && dram_req_ready;
    assign d_req_ready = grant_d && dram_req_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_busy_q    <= 1'b0;
            rd_owner_d_q <= 1'b0;
            prio_d_q     <= 1'b0;
        end else begin
            if (dram_rsp_valid && dram_rsp_ready) begin
                rd_busy_q <= 1'b0;
            end
            if (fire) begin
                prio_d_q <= grant_i;
                if (dram_req.read) begin
                    rd_busy_q    <= 1'b1;
                    rd_owner_d_q <= grant_d;
                end
            end
        end
    end

    // Response goes back to whoever owns the read
    assign dram_rsp_ready = rd_busy_q;
    assign i_rsp_valid    = dram_rsp_valid && rd_busy_q && !rd_owner_d_q;
    assign d_rsp_valid    = dram_rsp_valid && rd_busy_q && rd_owner_d_q;
    assign i_rsp_line     = dram_rsp.data[vx_mem_pkg::ILINE_WORDS-1:0];
    assign d_rsp_line     = dram_rsp.data;

    a_rsp_needs_read : assert property (@(posedge clk) disable iff (reset)
        dram_rsp_valid |-> rd_busy_q);

    a_grant_onehot : assert property (@(posedge clk) disable iff (reset)
        dram_req_valid |-> $onehot({grant_i, grant_d}));

endmodule

/* rtl/vx_line_buffer.sv */
module vx_line_buffer #(
    parameter type line_t   = vx_mem_pkg::dline_t,
    parameter bit  WRITE_EN = 1'b0
) (
    input  logic                  clk,
    input  logic                  reset,

    // Core request and response
    input  logic                  req_valid,
    input  vx_mem_pkg::core_req_t req,
    output logic                  req_ready,
    output logic                  rsp_valid,
    output vx_mem_pkg::core_rsp_t rsp,

    // Snoop invalidate
    input  logic                  snp_valid,
    input  logic [31:0]           snp_addr,

    // DRAM line request
    output logic                  dram_req_valid,
    output logic                  dram_req_read,
    output logic                  dram_req_write,
    output logic [31:0]           dram_req_addr,
    output line_t                 dram_req_line,
    input  logic                  dram_req_ready,

    // DRAM line response
    input  logic                  dram_rsp_valid,
    input  line_t                 dram_rsp_line
);

    localparam int WORD_W  = vx_mem_pkg::WORD_W;
    localparam int WORDS   = $bits(line_t) / WORD_W;
    localparam int OFF_W   = $clog2(WORDS);
    localparam int BYTE_W  = $clog2(WORD_W / 8);
    localparam int TAG_LSB = BYTE_W + OFF_W;
    localparam int TAG_W   = 32 - TAG_LSB;

    typedef logic [WORDS-1:0][WORD_W-1:0] words_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FILL,
        ST_WRITE,
        ST_RESP
    } state_t;

    state_t                state_q;
    logic                  valid_q;
    logic                  rd_sent_q;
    logic                  drop_q;
    logic [TAG_W-1:0]      tag_q;
    words_t                line_q;
    vx_mem_pkg::core_req_t req_q;

    logic                  accept;
    logic                  hit;
    logic                  req_wr;
    logic [TAG_W-1:0]      req_tag;
    logic [OFF_W-1:0]      req_off;
    logic                  q_wr;
    logic [TAG_W-1:0]      q_tag;
    logic [OFF_W-1:0]      q_off;
    logic [TAG_W-1:0]      snp_tag;
    words_t                fill_words;

    // Incoming request decode
    assign req_tag = req.addr[31:TAG_LSB];
    assign req_off = req.addr[TAG_LSB-1:BYTE_W];
    assign req_wr  = WRITE_EN && req.write;
    assign hit     = valid_q && (tag_q == req_tag);
    assign accept  = req_valid && req_ready;

    // Held request decode
    assign q_tag   = req_q.addr[31:TAG_LSB];
    assign q_off   = req_q.addr[TAG_LSB-1:BYTE_W];
    assign q_wr    = WRITE_EN && req_q.write;
    assign snp_tag = snp_addr[31:TAG_LSB];

    // Write-allocate: the store word lands on top of the returning line
    always_comb begin
        fill_words = words_t'(dram_rsp_line);
        if (q_wr) begin
            fill_words[q_off] = req_q.data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q   <= ST_IDLE;
            valid_q   <= 1'b0;
            rd_sent_q <= 1'b0;
            drop_q    <= 1'b0;
        end else begin
            case (state_q)
                ST_IDLE: begin
                    if (accept) begin
                        if (!hit) begin
                            // Old line is being replaced
                            valid_q <= 1'b0;
                            state_q <= ST_FILL;
                        end else if (req_wr) begin
                            state_q <= ST_WRITE;
                        end else begin
                            state_q <= ST_RESP;
                        end
                    end
                end
                ST_FILL: begin
                    if (dram_req_valid && dram_req_ready) begin
                        rd_sent_q <= 1'b1;
                    end
                    if (dram_rsp_valid) begin
                        rd_sent_q <= 1'b0;
                        valid_q   <= 1'b1;
                        state_q   <= q_wr ? ST_WRITE : ST_RESP;
                    end
                    // Snoop on the line in flight, kill it once answered
                    if (snp_valid && (snp_tag == q_tag)) begin
                        drop_q <= 1'b1;
                    end
                end
                ST_WRITE: begin
                    if (dram_req_ready) begin
                        state_q <= ST_RESP;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                    if (drop_q) begin
                        valid_q <= 1'b0;
                        drop_q  <= 1'b0;
                    end
                end
            endcase
            if (snp_valid && valid_q && (snp_tag == tag_q)) begin
                valid_q <= 1'b0;
            end
        end
    end

    // Line payload and held request
    always_ff @(posedge clk) begin
        if (accept) begin
            req_q <= req;
            if (hit && req_wr) begin
                line_q[req_off] <= req.data;
            end
        end
        if ((state_q == ST_FILL) && dram_rsp_valid) begin
            line_q <= fill_words;
            tag_q  <= q_tag;
        end
    end

    assign req_ready      = (state_q == ST_IDLE);
    assign dram_req_valid = ((state_q == ST_FILL) && !rd_sent_q) || (state_q == ST_WRITE);
    assign dram_req_read  = (state_q == ST_FILL);
    assign dram_req_write = (state_q == ST_WRITE);
    assign dram_req_addr  = {q_tag, {TAG_LSB{1'b0}}};
    assign dram_req_line  = line_t'(line_q);

    assign rsp_valid     = (state_q == ST_RESP);
    assign rsp.data      = line_q[q_off];
    assign rsp.write_ack = q_wr;

    a_no_write_when_ro : assert property (@(posedge clk) disable iff (reset)
        (req_valid && req_ready) |-> (WRITE_EN || !req.write));

    a_rsp_only_in_fill : assert property (@(posedge clk) disable iff (reset)
        dram_rsp_valid |-> (state_q == ST_FILL) && rd_sent_q);

    a_busy_while_dram : assert property (@(posedge clk) disable iff (reset)
        dram_req_valid |-> !req_ready);

endmodule

/* rtl/vx_mem_pkg.sv */
package vx_mem_pkg;

    // Data word width shared by both ports and the DRAM channel
    localparam int WORD_W = 32;

    // Default line sizes in words
    localparam int ILINE_WORDS = 4;
    localparam int DLINE_WORDS = 8;

    // Instruction line payload
    typedef logic [ILINE_WORDS-1:0][WORD_W-1:0] iline_t;

    // Data line payload, also the width of the DRAM channel
    typedef logic [DLINE_WORDS-1:0][WORD_W-1:0] dline_t;

    // Core side request, one word per transfer
    typedef struct packed {
        logic              write;
        logic [31:0]       addr;
        logic [WORD_W-1:0] data;
    } core_req_t;

    // Core side response
    typedef struct packed {
        logic [WORD_W-1:0] data;
        logic              write_ack;
    } core_rsp_t;

    // DRAM request, a full line per transfer
    typedef struct packed {
        logic        read;
        logic        write;
        logic [31:0] addr;
        dline_t      data;
    } dram_req_t;

    // DRAM read response
    typedef struct packed {
        logic [31:0] addr;
        dline_t      data;
    } dram_rsp_t;

endpackage

/* rtl/vx_mem_tile.sv */
module vx_mem_tile #(
    parameter logic [31:0] IO_BUS_ADDR = 32'hFFFF_FF00,
    parameter int          ILINE_WORDS = vx_mem_pkg::ILINE_WORDS,
    parameter int          DLINE_WORDS = vx_mem_pkg::DLINE_WORDS
) (
    input  logic                  clk,
    input  logic                  reset,

    // Instruction fetch port
    input  logic                  i_req_valid,
    input  vx_mem_pkg::core_req_t i_req,
    output logic                  i_req_ready,
    output logic                  i_rsp_valid,
    output vx_mem_pkg::core_rsp_t i_rsp,

    // Data port
    input  logic                  d_req_valid,
    input  vx_mem_pkg::core_req_t d_req,
    output logic                  d_req_ready,
    output logic                  d_rsp_valid,
    output vx_mem_pkg::core_rsp_t d_rsp,

    // IO bus
    output logic                  io_valid,
    output logic [31:0]           io_data,

    // LLC snoop
    input  logic                  llc_snp_req_valid,
    input  logic [31:0]           llc_snp_req_addr,

    // DRAM channel
    output logic                  dram_req_valid,
    output vx_mem_pkg::dram_req_t dram_req,
    input  logic                  dram_req_ready,
    input  logic                  dram_rsp_valid,
    input  vx_mem_pkg::dram_rsp_t dram_rsp,
    output logic                  dram_rsp_ready
);

    typedef logic [ILINE_WORDS-1:0][vx_mem_pkg::WORD_W-1:0] ifetch_line_t;
    typedef logic [DLINE_WORDS-1:0][vx_mem_pkg::WORD_W-1:0] data_line_t;

    logic                  d_lb_valid;

    logic                  i_dram_valid;
    logic                  i_dram_read;
    logic                  i_dram_write;
    logic [31:0]           i_dram_addr;
    logic                  i_dram_ready;
    logic                  i_fill_valid;
    ifetch_line_t          i_fill_line;

    logic                  d_dram_valid;
    vx_mem_pkg::dram_req_t d_dram_req;
    data_line_t            d_dram_line;
    logic                  d_dram_ready;
    logic                  d_fill_valid;
    data_line_t            d_fill_line;

    // Store to the IO address is taken off the data path
    assign io_valid = d_req_valid && d_req.write && (d_req.addr == IO_BUS_ADDR) && d_req_ready;
    assign io_data  = d_req.data;

    assign d_lb_valid = d_req_valid && !io_valid;

    vx_line_buffer #(
        .line_t   (ifetch_line_t),
        .WRITE_EN (1'b0)
    ) icache_lb (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (i_req_valid),
        .req            (i_req),
        .req_ready      (i_req_ready),
        .rsp_valid      (i_rsp_valid),
        .rsp            (i_rsp),
        .snp_valid      (llc_snp_req_valid),
        .snp_addr       (llc_snp_req_addr),
        .dram_req_valid (i_dram_valid),
        .dram_req_read  (i_dram_read),
        .dram_req_write (i_dram_write),
        .dram_req_addr  (i_dram_addr),
        .dram_req_line  (),
        .dram_req_ready (i_dram_ready),
        .dram_rsp_valid (i_fill_valid),
        .dram_rsp_line  (i_fill_line)
    );

    vx_line_buffer #(
        .line_t   (data_line_t),
        .WRITE_EN (1'b1)
    ) dcache_lb (
        .clk            (clk),
        .reset          (reset),
        .req_valid      (d_lb_valid),
        .req            (d_req),
        .req_ready      (d_req_ready),
        .rsp_valid      (d_rsp_valid),
        .rsp            (d_rsp),
        .snp_valid      (llc_snp_req_valid),
        .snp_addr       (llc_snp_req_addr),
        .dram_req_valid (d_dram_valid),
        .dram_req_read  (d_dram_req.read),
        .dram_req_write (d_dram_req.write),
        .dram_req_addr  (d_dram_req.addr),
        .dram_req_line  (d_dram_line),
        .dram_req_ready (d_dram_ready),
        .dram_rsp_valid (d_fill_valid),
        .dram_rsp_line  (d_fill_line)
    );

    assign d_dram_req.data = d_dram_line;

    vx_dram_arbiter dram_arb (
        .clk            (clk),
        .reset          (reset),
        .i_req_valid    (i_dram_valid),
        .i_req_addr     (i_dram_addr),
        .i_req_ready    (i_dram_ready),
        .i_rsp_valid    (i_fill_valid),
        .i_rsp_line     (i_fill_line),
        .d_req_valid    (d_dram_valid),
        .d_req          (d_dram_req),
        .d_req_ready    (d_dram_ready),
        .d_rsp_valid    (d_fill_valid),
        .d_rsp_line     (d_fill_line),
        .dram_req_valid (dram_req_valid),
        .dram_req       (dram_req),
        .dram_req_ready (dram_req_ready),
        .dram_rsp_valid (dram_rsp_valid),
        .dram_rsp       (dram_rsp),
        .dram_rsp_ready (dram_rsp_ready)
    );

    // Arbiter widens the fetch side as a plain read and drops its line
    a_ifetch_read_only : assert property (@(posedge clk) disable iff (reset)
        i_dram_valid |-> i_dram_read && !i_dram_write);

    // IO store never reaches the data line buffer or DRAM
    a_io_no_dram : assert property (@(posedge clk) disable iff (reset)
        io_valid |=> !d_dram_valid && !d_rsp_valid);

endmodule

/* run_sim.sh */
#!/bin/sh
# Compile and run the tile testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f vlog.f \
    --top-module tb_vx_mem_tile -o tb_vx_mem_tile

./obj_dir/tb_vx_mem_tile > sim.log 2>&1 || true
cat sim.log

if grep -q "^Finished with no errors$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* vlog.f */
rtl/vx_mem_pkg.sv
rtl/vx_line_buffer.sv
rtl/vx_dram_arbiter.sv
rtl/vx_mem_tile.sv
dv/vx_dram_model.sv
dv/tb_vx_mem_tile.sv
